/* src/tomasulo_pkg.sv */
package tomasulo_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // reorder buffer entries, the tag width follows from it
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = $clog2(ROB_DEPTH);

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [31:0]      word_t;

    //////////////////////////////////////////////////
    // alu operations
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui and forced no-ops just pass the second operand
        alu_pass_b = 4'd10
    } alu_op_t;

    //////////////////////////////////////////////////
    // structs shared between blocks
    //////////////////////////////////////////////////

    // either a ready value or the tag of its producer
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        alu_op_t  op;
        operand_t src1;
        operand_t src2;
        tag_t     rd_tag;
    } issue_word_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } cdb_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        word_t      data;
    } commit_t;

endpackage : tomasulo_pkg

/* src/instr_queue.sv */
module instr_queue
import tomasulo_pkg::*;
#(
    parameter int NUM_RS = 2
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              instr_resp_i,
    input  word_t             instr_rdata_i,
    output logic              instr_read_o,
    output word_t             instr_addr_o,
    output logic [4:0]        rs1_o,
    output logic [4:0]        rs2_o,
    input  operand_t          reg1_i,
    input  operand_t          reg2_i,
    input  operand_t          rob1_i,
    input  operand_t          rob2_i,
    input  tag_t              tail_tag_i,
    input  logic              rob_full_i,
    input  logic [NUM_RS-1:0] rs_empty_i,
    output logic [NUM_RS-1:0] rs_load_o,
    output logic              alloc_o,
    output logic [4:0]        rd_o,
    output issue_word_t       issue_o
);

logic       read_q;
word_t      pc_q;
logic       dec_valid_q;
word_t      ir_q;
logic       issue;
logic [6:0] opcode;
logic [2:0] funct3;
logic       is_op;
logic       is_imm;
logic       is_lui;
logic       use_imm;
word_t      imm;
alu_op_t    op;

// register file value first, then a finished rob entry, else wait on the tag
function automatic operand_t resolve(operand_t reg_opnd, operand_t rob_opnd);
    operand_t res;
    res = reg_opnd;
    if (!reg_opnd.valid) begin
        res.valid = rob_opnd.valid;
        res.data  = rob_opnd.valid ? rob_opnd.data : '0;
    end
    return res;
endfunction

//////////////////////////////////////////////////
// fetch and decode register
//////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst_i) begin
        read_q      <= 1'b0;
        pc_q        <= '0;
        dec_valid_q <= 1'b0;
    end else begin
        if (issue) begin
            dec_valid_q <= 1'b0;
        end
        if (read_q) begin
            if (instr_resp_i) begin
                read_q      <= 1'b0;
                pc_q        <= pc_q + 32'd4;
                dec_valid_q <= 1'b1;
            end
        end else if (!dec_valid_q || issue) begin
            read_q <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (read_q && instr_resp_i) begin
        ir_q <= instr_rdata_i;
    end
end

assign instr_read_o = read_q;
assign instr_addr_o = pc_q;

//////////////////////////////////////////////////
// decode
//////////////////////////////////////////////////

always_comb begin
    opcode  = ir_q[6:0];
    funct3  = ir_q[14:12];
    is_op   = (opcode == 7'b0110011);
    is_imm  = (opcode == 7'b0010011);
    is_lui  = (opcode == 7'b0110111);
    use_imm = !is_op;
    rs1_o   = ir_q[19:15];
    rs2_o   = ir_q[24:20];
    rd_o    = ir_q[11:7];
    imm     = is_lui ? {ir_q[31:12], 12'h000} : {{20{ir_q[31]}}, ir_q[31:20]};
    case (funct3)
        3'b000:  op = (is_op && ir_q[30]) ? alu_sub : alu_add;
        3'b001:  op = alu_sll;
        3'b010:  op = alu_slt;
        3'b011:  op = alu_sltu;
        3'b100:  op = alu_xor;
        3'b101:  op = ir_q[30] ? alu_sra : alu_srl;
        3'b110:  op = alu_or;
        default: op = alu_and;
    endcase
    if (is_lui) begin
        op    = alu_pass_b;
        rs1_o = '0;
    end
    // unsupported opcodes and any write to x0 become a zero write to x0
    if (!(is_op || is_imm || is_lui) || rd_o == 5'd0) begin
        op      = alu_pass_b;
        rs1_o   = '0;
        rd_o    = '0;
        imm     = '0;
        use_imm = 1'b1;
    end
end

//////////////////////////////////////////////////
// issue
//////////////////////////////////////////////////

assign issue   = dec_valid_q && (|rs_empty_i) && !rob_full_i;
assign alloc_o = issue;

always_comb begin
    issue_o.op     = op;
    issue_o.src1   = resolve(reg1_i, rob1_i);
    issue_o.src2   = resolve(reg2_i, rob2_i);
    issue_o.rd_tag = tail_tag_i;
    if (use_imm) begin
        issue_o.src2.valid = 1'b1;
        issue_o.src2.tag   = '0;
        issue_o.src2.data  = imm;
    end
end

// lowest empty station wins
always_comb begin
    rs_load_o = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin
        if (rs_empty_i[i]) begin
            rs_load_o    = '0;
            rs_load_o[i] = issue;
        end
    end
end

endmodule : instr_queue

/* src/tag_regfile.sv */
module tag_regfile
import tomasulo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    output operand_t   reg1_o,
    output operand_t   reg2_o,
    input  logic       alloc_i,
    input  logic [4:0] rd_i,
    input  tag_t       tag_i,
    input  commit_t    commit_i,
    input  tag_t       commit_tag_i
);

word_t       value_q [32];
tag_t        tag_q   [32];
logic [31:0] busy_q;

always_ff @(posedge clk) begin
    if (rst_i) begin
        busy_q <= '0;
        for (int i = 0; i < 32; i++) begin
            value_q[i] <= '0;
            tag_q[i]   <= '0;
        end
    end else begin
        // only the newest producer of a register may retire into it
        if (commit_i.valid && commit_i.rd != 5'd0 && busy_q[commit_i.rd]
                && tag_q[commit_i.rd] == commit_tag_i) begin
            value_q[commit_i.rd] <= commit_i.data;
            busy_q[commit_i.rd]  <= 1'b0;
        end
        // a new allocation wins over the clear above
        if (alloc_i && rd_i != 5'd0) begin
            busy_q[rd_i] <= 1'b1;
            tag_q[rd_i]  <= tag_i;
        end
    end
end

always_comb begin
    reg1_o.valid = !busy_q[rs1_i];
    reg1_o.tag   = tag_q[rs1_i];
    reg1_o.data  = value_q[rs1_i];
    reg2_o.valid = !busy_q[rs2_i];
    reg2_o.tag   = tag_q[rs2_i];
    reg2_o.data  = value_q[rs2_i];
end

endmodule : tag_regfile

/* src/reorder_buffer.sv */
module reorder_buffer
import tomasulo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       alloc_i,
    input  logic [4:0] rd_i,
    output tag_t       tail_tag_o,
    output logic       rob_full_o,
    input  tag_t       look1_i,
    input  tag_t       look2_i,
    output operand_t   rob1_o,
    output operand_t   rob2_o,
    input  cdb_t       cdb_i,
    output commit_t    commit_o,
    output tag_t       commit_tag_o
);

tag_t                   head_q;
tag_t                   tail_q;
logic [TAG_W:0]         count_q;
logic [ROB_DEPTH-1:0]   done_q;
logic [4:0]             rd_q    [ROB_DEPTH];
word_t                  value_q [ROB_DEPTH];
logic                   retire;

assign retire     = (count_q != '0) && done_q[head_q];
assign rob_full_o = (count_q == ROB_DEPTH[TAG_W:0]);
assign tail_tag_o = tail_q;

//////////////////////////////////////////////////
// pointers and status
//////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst_i) begin
        head_q  <= '0;
        tail_q  <= '0;
        count_q <= '0;
        done_q  <= '0;
    end else begin
        if (alloc_i) begin
            done_q[tail_q] <= 1'b0;
            tail_q         <= tail_q + 1'b1;
        end
        if (cdb_i.valid) begin
            done_q[cdb_i.tag] <= 1'b1;
        end
        if (retire) begin
            head_q <= head_q + 1'b1;
        end
        count_q <= count_q + alloc_i - retire;
    end
end

// entry payload
always_ff @(posedge clk) begin
    if (alloc_i) begin
        rd_q[tail_q] <= rd_i;
    end
    if (cdb_i.valid) begin
        value_q[cdb_i.tag] <= cdb_i.data;
    end
end

//////////////////////////////////////////////////
// lookup and commit
//////////////////////////////////////////////////

always_comb begin
    rob1_o.valid   = done_q[look1_i];
    rob1_o.tag     = look1_i;
    rob1_o.data    = value_q[look1_i];
    rob2_o.valid   = done_q[look2_i];
    rob2_o.tag     = look2_i;
    rob2_o.data    = value_q[look2_i];
    commit_o.valid = retire;
    commit_o.rd    = rd_q[head_q];
    commit_o.data  = value_q[head_q];
    commit_tag_o   = head_q;
end

endmodule : reorder_buffer

/* src/reservation_station.sv */
module reservation_station
import tomasulo_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        load_i,
    input  issue_word_t word_i,
    input  cdb_t        cdb_i,
    input  logic        grant_i,
    output logic        req_o,
    output cdb_t        result_o,
    output logic        empty_o
);

issue_word_t word_q;
logic        busy_q;
logic        done_q;
logic        ready;
word_t       result_q;
word_t       alu_out;
word_t       a;
word_t       b;

// pick up a waiting operand when its producer is on the bus
function automatic operand_t capture(operand_t opnd, cdb_t bus);
    operand_t res;
    res = opnd;
    if (!opnd.valid && bus.valid && bus.tag == opnd.tag) begin
        res.valid = 1'b1;
        res.data  = bus.data;
    end
    return res;
endfunction

assign ready = busy_q && !done_q && word_q.src1.valid && word_q.src2.valid;

//////////////////////////////////////////////////
// station state
//////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b0;
    end else if (load_i) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
    end else if (grant_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b0;
    end else if (ready) begin
        done_q <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (load_i) begin
        word_q      <= word_i;
        word_q.src1 <= capture(word_i.src1, cdb_i);
        word_q.src2 <= capture(word_i.src2, cdb_i);
    end else if (busy_q) begin
        word_q.src1 <= capture(word_q.src1, cdb_i);
        word_q.src2 <= capture(word_q.src2, cdb_i);
    end
    // result is held until the bus is granted
    if (ready) begin
        result_q <= alu_out;
    end
end

//////////////////////////////////////////////////
// alu
//////////////////////////////////////////////////

always_comb begin
    a = word_q.src1.data;
    b = word_q.src2.data;
    case (word_q.op)
        alu_add:  alu_out = a + b;
        alu_sub:  alu_out = a - b;
        alu_sll:  alu_out = a << b[4:0];
        alu_slt:  alu_out = {31'h0, $signed(a) < $signed(b)};
        alu_sltu: alu_out = {31'h0, a < b};
        alu_xor:  alu_out = a ^ b;
        alu_srl:  alu_out = a >> b[4:0];
        alu_sra:  alu_out = $signed(a) >>> b[4:0];
        alu_or:   alu_out = a | b;
        alu_and:  alu_out = a & b;
        default:  alu_out = b;
    endcase
end

assign req_o          = done_q;
assign empty_o        = !busy_q;
assign result_o.valid = done_q;
assign result_o.tag   = word_q.rd_tag;
assign result_o.data  = result_q;

endmodule : reservation_station

/* src/cdb_arbiter.sv */
module cdb_arbiter
import tomasulo_pkg::*;
#(
    parameter int NUM_RS = 2
) (
    input  logic [NUM_RS-1:0] req_i,
    input  cdb_t [NUM_RS-1:0] result_i,
    output logic [NUM_RS-1:0] grant_o,
    output cdb_t              cdb_o
);

// fixed priority, station 0 first
always_comb begin
    grant_o = '0;
    cdb_o   = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin
        if (req_i[i]) begin
            grant_o    = '0;
            grant_o[i] = 1'b1;
            cdb_o      = result_i[i];
        end
    end
end

endmodule : cdb_arbiter

/* src/ooo_core.sv */
module ooo_core
import tomasulo_pkg::*;
#(
    parameter int NUM_RS = 2
) (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    instr_resp_i,
    input  word_t   instr_rdata_i,
    output logic    instr_read_o,
    output word_t   instr_addr_o,
    output commit_t commit_o
);

//////////////////////////////////////////////////
// interconnect
//////////////////////////////////////////////////

logic [4:0]        rs1;
logic [4:0]        rs2;
logic [4:0]        rd;
operand_t          reg1;
operand_t          reg2;
operand_t          rob1;
operand_t          rob2;
tag_t              tail_tag;
tag_t              commit_tag;
logic              rob_full;
logic              alloc;
issue_word_t       issue_word;
logic [NUM_RS-1:0] rs_empty;
logic [NUM_RS-1:0] rs_load;
logic [NUM_RS-1:0] rs_req;
logic [NUM_RS-1:0] rs_grant;
cdb_t [NUM_RS-1:0] rs_result;
cdb_t              cdb;

instr_queue #(.NUM_RS(NUM_RS)) iq (
    .clk(clk), .rst_i(rst_i),
    .instr_resp_i(instr_resp_i), .instr_rdata_i(instr_rdata_i),
    .instr_read_o(instr_read_o), .instr_addr_o(instr_addr_o),
    .rs1_o(rs1), .rs2_o(rs2), .reg1_i(reg1), .reg2_i(reg2),
    .rob1_i(rob1), .rob2_i(rob2), .tail_tag_i(tail_tag), .rob_full_i(rob_full),
    .rs_empty_i(rs_empty), .rs_load_o(rs_load), .alloc_o(alloc),
    .rd_o(rd), .issue_o(issue_word)
);

tag_regfile regfile (
    .clk(clk), .rst_i(rst_i), .rs1_i(rs1), .rs2_i(rs2),
    .reg1_o(reg1), .reg2_o(reg2), .alloc_i(alloc), .rd_i(rd), .tag_i(tail_tag),
    .commit_i(commit_o), .commit_tag_i(commit_tag)
);

// busy sources are looked up by their producer tag
reorder_buffer rob (
    .clk(clk), .rst_i(rst_i), .alloc_i(alloc), .rd_i(rd),
    .tail_tag_o(tail_tag), .rob_full_o(rob_full),
    .look1_i(reg1.tag), .look2_i(reg2.tag), .rob1_o(rob1), .rob2_o(rob2),
    .cdb_i(cdb), .commit_o(commit_o), .commit_tag_o(commit_tag)
);

for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
    reservation_station rs (
        .clk(clk), .rst_i(rst_i), .load_i(rs_load[i]), .word_i(issue_word),
        .cdb_i(cdb), .grant_i(rs_grant[i]), .req_o(rs_req[i]),
        .result_o(rs_result[i]), .empty_o(rs_empty[i])
    );
end

cdb_arbiter #(.NUM_RS(NUM_RS)) arbiter (
    .req_i(rs_req), .result_i(rs_result), .grant_o(rs_grant), .cdb_o(cdb)
);

endmodule : ooo_core

/* verif/ooo_core_tb.sv */
module ooo_core_tb
import tomasulo_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int    MAX_ROWS       = 64;
localparam int    TIMEOUT_CYCLES = 2000;
localparam word_t NOP_WORD       = 32'h0000_0013;

logic    clk           = 1'b0;
logic    rst_i         = 1'b1;
logic    instr_resp_i  = 1'b0;
word_t   instr_rdata_i = '0;
logic    instr_read_o;
word_t   instr_addr_o;
commit_t commit_o;

// raw file contents with three words per program row
word_t      stim      [3*MAX_ROWS];
word_t      prog_word [MAX_ROWS];
logic [4:0] exp_rd    [MAX_ROWS];
word_t      exp_data  [MAX_ROWS];
int         num_rows      = 0;
int         commit_cnt    = 0;
int         reset_errors  = 0;
int         fetch_errors  = 0;
int         commit_errors = 0;
logic       timed_out     = 1'b0;
word_t      expect_addr   = '0;
int         resp_delay    = 0;

always #5 clk = ~clk;

ooo_core #(.NUM_RS(2)) dut0 (
    .clk(clk), .rst_i(rst_i),
    .instr_resp_i(instr_resp_i), .instr_rdata_i(instr_rdata_i),
    .instr_read_o(instr_read_o), .instr_addr_o(instr_addr_o),
    .commit_o(commit_o)
);

//////////////////////////////////////////////////
// stimulus file
//////////////////////////////////////////////////

task automatic load_stimulus();
    // entries the file does not reach read as an impossible rd and end the list
    for (int i = 0; i < 3*MAX_ROWS; i++) begin
        stim[i] = 32'hfeed_0000 | i;
    end
    $readmemh("verif/core_stimulus.txt", stim);
    while (num_rows < MAX_ROWS && stim[3*num_rows+1] < 32) begin
        prog_word[num_rows] = stim[3*num_rows];
        exp_rd[num_rows]    = stim[3*num_rows+1][4:0];
        exp_data[num_rows]  = stim[3*num_rows+2];
        num_rows++;
    end
    if (num_rows == 0) begin
        $display("Error: the stimulus file gave no program rows");
        commit_errors++;
    end
endtask

//////////////////////////////////////////////////
// instruction memory
//////////////////////////////////////////////////

// past the end of the program the core sees addi x0, x0, 0
function automatic word_t fetch_word(word_t addr);
    int    idx;
    word_t res;
    idx = int'(addr >> 2);
    if (idx < num_rows) begin
        res = prog_word[idx];
    end else begin
        res = NOP_WORD;
    end
    return res;
endfunction

always @(posedge clk) begin
    if (rst_i) begin
        instr_resp_i <= 1'b0;
        expect_addr  <= '0;
        resp_delay   <= $urandom % 4;
    end else begin
        if (instr_read_o) begin
            // address must be held and step by one word per response
            fetch_addr: assert (instr_addr_o == expect_addr) else begin
                $display("Error fetch address: expected 0x%08h, actual 0x%08h",
                         expect_addr, instr_addr_o);
                fetch_errors++;
            end
        end
        if (instr_read_o && instr_resp_i) begin
            // the word is taken and the next read waits a fresh delay
            instr_resp_i <= 1'b0;
            expect_addr  <= expect_addr + 32'd4;
            resp_delay   <= $urandom % 4;
        end else if (instr_read_o && resp_delay > 1) begin
            resp_delay <= resp_delay - 1;
        end else if (instr_read_o || resp_delay == 0) begin
            // with no delay the word is offered ahead and answers the read at once
            instr_resp_i  <= 1'b1;
            instr_rdata_i <= fetch_word(expect_addr);
        end
    end
end

//////////////////////////////////////////////////
// reset and commit checks
//////////////////////////////////////////////////

task automatic apply_reset();
    repeat (2) begin
        @(posedge clk);
        @(negedge clk);
        reset_fetch: assert (instr_read_o == 1'b0) else begin
            $display("Error reset fetch: expected 0, actual %0b", instr_read_o);
            reset_errors++;
        end
        reset_commit: assert (commit_o.valid == 1'b0) else begin
            $display("Error reset commit: expected 0, actual %0b", commit_o.valid);
            reset_errors++;
        end
    end
    @(posedge clk);
    rst_i <= 1'b0;
endtask

task automatic check_commit();
    string name;
    name = $sformatf("commit %0d", commit_cnt);
    commit_rd: assert (commit_o.rd == exp_rd[commit_cnt]) else begin
        $display("Error %s rd: expected %0d, actual %0d",
                 name, exp_rd[commit_cnt], commit_o.rd);
        commit_errors++;
    end
    commit_data: assert (commit_o.data == exp_data[commit_cnt]) else begin
        $display("Error %s data: expected 0x%08h, actual 0x%08h",
                 name, exp_data[commit_cnt], commit_o.data);
        commit_errors++;
    end
    commit_cnt++;
endtask

// commits are taken on the falling edge in program order
task automatic collect_commits();
    int cycles;
    cycles = 0;
    while (commit_cnt < num_rows && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        cycles++;
        if (commit_o.valid) begin
            check_commit();
        end
    end
    if (commit_cnt < num_rows) begin
        $display("Error: timeout after %0d cycles with %0d of %0d commits seen",
                 cycles, commit_cnt, num_rows);
        timed_out = 1'b1;
    end
endtask

initial begin
    int total;
    void'($urandom(32'h239a));
    load_stimulus();
    apply_reset();
    collect_commits();
    total = reset_errors + fetch_errors + commit_errors + int'(timed_out);
    $display("error count %0d: reset %0d, fetch %0d, commit %0d, timeout %0d",
             total, reset_errors, fetch_errors, commit_errors, timed_out);
    if (total == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule : ooo_core_tb

/* verif/core_stimulus.txt */
// columns: instruction word, expected commit rd, expected commit value, all hex
// one row per instruction in program order from address 0
123450b7 01 12345000 // lui   x1, 0x12345
06400113 02 00000064 // addi  x2, x0, 100
ff900193 03 fffffff9 // addi  x3, x0, -7
00310233 04 0000005d // add   x4, x2, x3
402202b3 05 fffffff9 // sub   x5, x4, x2
00411313 06 00000640 // slli  x6, x2, 4
4011d393 07 fffffffc // srai  x7, x3, 1
01c1d413 08 0000000f // srli  x8, x3, 28
0021a4b3 09 00000001 // slt   x9, x3, x2
0021b533 0a 00000000 // sltu  x10, x3, x2
0060c5b3 0b 12345640 // xor   x11, x1, x6
0075e633 0c fffffffc // or    x12, x11, x7
001676b3 0d 12345000 // and   x13, x12, x1
00120213 04 0000005e // addi  x4, x4, 1
00120213 04 0000005f // addi  x4, x4, 1
00508013 00 00000000 // addi  x0, x1, 5
00221733 0e 000005f0 // sll   x14, x4, x2
004707b3 0f 0000064f // add   x15, x14, x4
fff7c813 10 fffff9b0 // xori  x16, x15, -1
0ff87893 11 000000b0 // andi  x17, x16, 0xff
abcde937 12 abcde000 // lui   x18, 0xabcde
12396993 13 abcde123 // ori   x19, x18, 0x123
00001a17 00 00000000 // auipc x20, 1 is not supported and writes x0
0001aa13 14 00000001 // slti  x20, x3, 0
06513a93 15 00000001 // sltiu x21, x2, 0x65
015a0b33 16 00000002 // add   x22, x20, x21

/* tb.f */
src/tomasulo_pkg.sv
src/instr_queue.sv
src/tag_regfile.sv
src/reorder_buffer.sv
src/reservation_station.sv
src/cdb_arbiter.sv
src/ooo_core.sv
verif/ooo_core_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f tb.f --top-module ooo_core_tb -o sim_ooo_core
./obj_dir/sim_ooo_core | tee sim.log
if grep -q "NO ERRORS" sim.log; then
    exit 0
fi
exit 1
